/* pipe_tail.f */
+incdir+rtl
rtl/pipe_pkg.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/reg_file.sv
rtl/pipe_tail.sv
tb/pipe_tail_assertions.sv
tb/pipe_tail_tb.sv

/* rtl/data_ram.sv */
`include "pipe_defines.svh"

module data_ram (
    input  logic                clk,
    input  logic                we,
    input  logic [`DRAM_AW-1:0] addr,   // word address
    input  logic [`DATA_W-1:0]  wdata,
    output logic [`DATA_W-1:0]  rdata
);

    logic [`DATA_W-1:0] mem [`DRAM_DEPTH];

    // known contents at time zero, loads of untouched words give 0
    initial begin
        for (int i = 0; i < `DRAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // write on the edge
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // async read, load result is ready in the same cycle
    assign rdata = mem[addr];

endmodule

/* rtl/mem_stage.sv */
`include "pipe_defines.svh"

module mem_stage
    import pipe_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    // from execute
    input  logic                es_to_ms_valid,
    input  es_to_ms_bus_t       es_to_ms_bus,
    output logic                ms_allowin,
    // to writeback
    input  logic                ws_allowin,
    output logic                ms_to_ws_valid,
    output ms_to_ws_bus_t       ms_to_ws_bus,
    // data ram port
    output logic                ram_we,
    output logic [`DRAM_AW-1:0] ram_addr,
    output logic [`DATA_W-1:0]  ram_wdata,
    input  logic [`DATA_W-1:0]  ram_rdata,
    // forwarding to decode
    output logic [`REG_AW-1:0]  ms_fwd_dest,
    output logic [`DATA_W-1:0]  ms_fwd_result
);

    logic               ms_valid;
    logic               ms_ready_go;
    es_to_ms_bus_t      es_to_ms_bus_r;   // payload, no reset
    logic               is_mem_op;
    logic               misaligned;
    logic               ms_ex;
    logic [`DATA_W-1:0] final_result;

    // never stalls today, hook left for a multi-cycle memory later
    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            es_to_ms_bus_r <= es_to_ms_bus;
        end
    end

    // word accesses only, low two address bits must be 0
    assign is_mem_op  = (es_to_ms_bus_r.mem_op == MEM_LOAD) ||
                        (es_to_ms_bus_r.mem_op == MEM_STORE);
    assign misaligned = is_mem_op && (|es_to_ms_bus_r.alu_result[`WORD_OFS-1:0]);
    assign ms_ex      = es_to_ms_bus_r.ex || misaligned;  // merge with upstream ex

    // store goes out only for a live, clean instruction
    assign ram_we    = ms_valid && (es_to_ms_bus_r.mem_op == MEM_STORE) && !ms_ex;
    assign ram_addr  = es_to_ms_bus_r.alu_result[`DRAM_AW+`WORD_OFS-1:`WORD_OFS];
    assign ram_wdata = es_to_ms_bus_r.store_data;

    // loads take the ram word, everything else passes the alu result
    assign final_result = (es_to_ms_bus_r.mem_op == MEM_LOAD) ? ram_rdata
                                                              : es_to_ms_bus_r.alu_result;

    always_comb begin
        ms_to_ws_bus.ex           = ms_ex;
        ms_to_ws_bus.gr_we        = es_to_ms_bus_r.gr_we;
        ms_to_ws_bus.dest         = es_to_ms_bus_r.dest;
        ms_to_ws_bus.final_result = final_result;
        ms_to_ws_bus.pc           = es_to_ms_bus_r.pc;
    end

    // dest 0 means nothing to forward
    assign ms_fwd_dest   = (ms_valid && es_to_ms_bus_r.gr_we && !ms_ex) ?
                           es_to_ms_bus_r.dest : '0;
    assign ms_fwd_result = final_result;

endmodule

/* rtl/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// machine word
`define DATA_W      32

// general register file
`define REG_NUM     32
`define REG_AW      5    // log2 of REG_NUM

// on-chip data ram, in words
`define DRAM_DEPTH  64
`define DRAM_AW     6    // word address bits

// byte offset bits inside a word
`define WORD_OFS    2

`endif

/* rtl/pipe_pkg.sv */
`include "pipe_defines.svh"

package pipe_pkg;

    // memory access kind carried down from execute
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // execute -> memory stage
    typedef struct packed {
        logic                ex;          // raised upstream
        mem_op_e             mem_op;
        logic                gr_we;
        logic [`REG_AW-1:0]  dest;
        logic [`DATA_W-1:0]  alu_result;  // also the load/store address
        logic [`DATA_W-1:0]  store_data;
        logic [`DATA_W-1:0]  pc;
        logic                pad;
    } es_to_ms_bus_t;

    // memory -> writeback stage
    typedef struct packed {
        logic                ex;
        logic                gr_we;
        logic [`REG_AW-1:0]  dest;
        logic [`DATA_W-1:0]  final_result;
        logic [`DATA_W-1:0]  pc;
    } ms_to_ws_bus_t;

    // writeback -> register file write port
    typedef struct packed {
        logic                we;
        logic [`REG_AW-1:0]  waddr;
        logic [`DATA_W-1:0]  wdata;
    } ws_to_rf_bus_t;

endpackage

/* rtl/pipe_tail.sv */
`include "pipe_defines.svh"

module pipe_tail
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    // from execute
    input  logic               es_to_ms_valid,
    input  es_to_ms_bus_t      es_to_ms_bus,
    output logic               ms_allowin,
    // decode read ports
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2,
    // forwarding
    output logic [`REG_AW-1:0] ms_fwd_dest,
    output logic [`DATA_W-1:0] ms_fwd_result,
    output logic [`REG_AW-1:0] ws_fwd_dest,
    output logic [`DATA_W-1:0] ws_fwd_result,
    // trace
    output logic [`DATA_W-1:0] debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`DATA_W-1:0] debug_wb_rf_wdata
);

    logic                ws_allowin;
    logic                ms_to_ws_valid;
    ms_to_ws_bus_t       ms_to_ws_bus;
    ws_to_rf_bus_t       ws_to_rf_bus;
    logic                ram_we;
    logic [`DRAM_AW-1:0] ram_addr;
    logic [`DATA_W-1:0]  ram_wdata;
    logic [`DATA_W-1:0]  ram_rdata;

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .ms_fwd_dest    (ms_fwd_dest),
        .ms_fwd_result  (ms_fwd_result)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .ws_allowin        (ws_allowin),
        .ws_to_rf_bus      (ws_to_rf_bus),
        .ws_fwd_dest       (ws_fwd_dest),
        .ws_fwd_result     (ws_fwd_result),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk          (clk),
        .reset        (reset),
        .ws_to_rf_bus (ws_to_rf_bus),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2)
    );

endmodule

/* rtl/reg_file.sv */
`include "pipe_defines.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  ws_to_rf_bus_t      ws_to_rf_bus,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2
);

    logic [`DATA_W-1:0] regs [`REG_NUM];

    // r0 is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (ws_to_rf_bus.we && (ws_to_rf_bus.waddr != '0)) begin
            regs[ws_to_rf_bus.waddr] <= ws_to_rf_bus.wdata;
        end
    end

    // no write bypass, decode forwards from wb instead
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/wb_stage.sv */
`include "pipe_defines.svh"

module wb_stage
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    // from memory stage
    input  logic               ms_to_ws_valid,
    input  ms_to_ws_bus_t      ms_to_ws_bus,
    output logic               ws_allowin,
    // register file write port
    output ws_to_rf_bus_t      ws_to_rf_bus,
    // forwarding to decode
    output logic [`REG_AW-1:0] ws_fwd_dest,
    output logic [`DATA_W-1:0] ws_fwd_result,
    // trace port
    output logic [`DATA_W-1:0] debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`DATA_W-1:0] debug_wb_rf_wdata
);

    logic          ws_valid;
    logic          ws_ready_go;
    ms_to_ws_bus_t ms_to_ws_bus_r;
    logic          rf_we;

    assign ws_ready_go = 1'b1;   // last stage, nothing downstream
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ms_to_ws_bus_r <= ms_to_ws_bus;
        end
    end

    // an excepting instruction retires without touching the rf
    assign rf_we = ws_valid && ms_to_ws_bus_r.gr_we && !ms_to_ws_bus_r.ex;

    always_comb begin
        ws_to_rf_bus.we    = rf_we;
        ws_to_rf_bus.waddr = ms_to_ws_bus_r.dest;
        ws_to_rf_bus.wdata = ms_to_ws_bus_r.final_result;
    end

    assign ws_fwd_dest   = ms_to_ws_bus_r.dest & {`REG_AW{ws_valid}};  // zero when empty
    assign ws_fwd_result = ms_to_ws_bus_r.final_result;

    // byte enables of the trace, all or nothing for word writes
    assign debug_wb_pc       = ms_to_ws_bus_r.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ms_to_ws_bus_r.dest;
    assign debug_wb_rf_wdata = ms_to_ws_bus_r.final_result;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the pipe_tail testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module pipe_tail_tb \
    --Mdir obj_dir \
    -f pipe_tail.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vpipe_tail_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb/pipe_tail_assertions.sv */
module pipe_tail_assertions (
    input logic       clk,
    input logic       reset,
    input logic       ms_allowin,
    input logic       ms_valid,        // memory stage holds an instruction
    input logic       ms_up_ex,        // ex raised before the memory stage
    input logic [1:0] ms_addr_lo,      // byte offset of the held address
    input logic       ram_we,
    input logic [3:0] debug_wb_rf_wen
);

    // no stall source in the tail
    assert property (@(posedge clk) ms_allowin)
        else $error("ms_allowin went low");

    // covers every reset cycle and the first one after
    assert property (@(posedge clk) reset |=> (debug_wb_rf_wen == 4'h0))
        else $error("trace wen active during or right after reset");

    assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_wen == 4'h0) || (debug_wb_rf_wen == 4'hf))
        else $error("trace wen is neither all zeros nor all ones");

    // upstream ex or an unaligned word keeps the ram untouched
    assert property (@(posedge clk) disable iff (reset)
        (ms_valid && (ms_up_ex || (ms_addr_lo != 2'b00))) |-> !ram_we)
        else $error("data ram written by an excepting instruction");

endmodule

bind pipe_tail pipe_tail_assertions u_pipe_tail_assertions (
    .clk             (clk),
    .reset           (reset),
    .ms_allowin      (ms_allowin),
    .ms_valid        (ms_to_ws_valid),
    .ms_up_ex        (u_mem_stage.es_to_ms_bus_r.ex),
    .ms_addr_lo      (u_mem_stage.es_to_ms_bus_r.alu_result[1:0]),
    .ram_we          (ram_we),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

/* tb/pipe_tail_stimulus.txt */
# valid ex mem_op gr_we dest alu_result store_data pc raddr | expected: wen wnum wdata rdata
# all hex, mem_op 0 none 1 load 2 store, rdata is raddr after the line retires
1 0 0 1 01 11111111 00000000 bfc00000 01 f 01 11111111 11111111
1 0 0 1 02 22222222 00000000 bfc00004 02 f 02 22222222 22222222
1 0 0 1 03 deadbeef 00000000 bfc00008 03 f 03 deadbeef deadbeef
1 0 2 0 00 00000010 a5a5a5a5 bfc0000c 03 0 00 00000000 deadbeef
1 0 1 1 04 00000010 00000000 bfc00010 04 f 04 a5a5a5a5 a5a5a5a5
1 0 1 1 01 00000020 00000000 bfc00014 01 f 01 00000000 00000000
1 0 2 0 00 00000044 12345678 bfc00018 01 0 00 00000000 00000000
0 0 2 1 02 00000044 ffffffff 00000000 02 0 00 00000000 22222222
1 0 1 1 06 00000044 00000000 bfc0001c 06 f 06 12345678 12345678
1 1 0 1 02 99999999 00000000 bfc00020 02 0 00 00000000 22222222
1 0 2 0 00 00000014 55aa55aa bfc00024 02 0 00 00000000 22222222
1 0 1 1 03 00000012 00000000 bfc00028 03 0 00 00000000 deadbeef
1 0 2 0 00 00000016 0bad0bad bfc0002c 03 0 00 00000000 deadbeef
1 0 1 1 07 00000014 00000000 bfc00030 07 f 07 55aa55aa 55aa55aa
1 1 2 0 00 00000014 ffff0000 bfc00034 07 0 00 00000000 55aa55aa
1 0 1 1 08 00000014 00000000 bfc00038 08 f 08 55aa55aa 55aa55aa
1 0 0 1 00 87654321 00000000 bfc0003c 00 f 00 87654321 00000000
1 0 1 1 00 00000010 00000000 bfc00040 00 f 00 a5a5a5a5 00000000
0 0 0 0 00 00000000 00000000 00000000 04 0 00 00000000 a5a5a5a5
0 0 0 0 00 00000000 00000000 00000000 06 0 00 00000000 12345678
1 0 0 1 09 00000009 00000000 bfc00044 09 f 09 00000009 00000009
1 0 0 1 09 00000099 00000000 bfc00048 09 f 09 00000099 00000099
1 0 0 1 0a cafef00d 00000000 bfc0004c 0a f 0a cafef00d cafef00d
1 0 1 1 0b 00000044 00000000 bfc00050 0b f 0b 12345678 12345678
1 0 2 0 00 000000fc 76543210 bfc00054 0b 0 00 00000000 12345678
1 0 1 1 0c 000000fc 00000000 bfc00058 0c f 0c 76543210 76543210
1 0 0 0 05 00005555 00000000 bfc0005c 05 0 00 00000000 00000000
0 0 0 0 00 00000000 00000000 00000000 09 0 00 00000000 00000099

/* tb/pipe_tail_tb.sv */
`include "pipe_defines.svh"

module pipe_tail_tb
    import pipe_pkg::*;
();

    localparam int MAX_LINES = 64;

    // one stimulus file line with inputs and expected results
    typedef struct packed {
        logic               valid;
        es_to_ms_bus_t      bus;
        logic [`REG_AW-1:0] raddr;       // readback register
        logic [3:0]         exp_wen;
        logic [`REG_AW-1:0] exp_wnum;
        logic [`DATA_W-1:0] exp_wdata;
        logic [`DATA_W-1:0] exp_rdata;   // value of raddr after this line retires
    } stim_line_t;

    logic               clk;
    logic               reset;
    logic               es_to_ms_valid;
    es_to_ms_bus_t      es_to_ms_bus;
    logic               ms_allowin;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`DATA_W-1:0] rdata1;
    logic [`DATA_W-1:0] rdata2;
    logic [`REG_AW-1:0] ms_fwd_dest;
    logic [`DATA_W-1:0] ms_fwd_result;
    logic [`REG_AW-1:0] ws_fwd_dest;
    logic [`DATA_W-1:0] ws_fwd_result;
    logic [`DATA_W-1:0] debug_wb_pc;
    logic [3:0]         debug_wb_rf_wen;
    logic [`REG_AW-1:0] debug_wb_rf_wnum;
    logic [`DATA_W-1:0] debug_wb_rf_wdata;

    stim_line_t lines [MAX_LINES];
    int         n_lines = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 0;   // 0 until the file is read
    int         checks_run = 0;

    pipe_tail dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: simulation ran past %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task check_value(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
        checks_run++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task read_stimulus();
        int          fd;
        int          code;
        string       text;
        logic [31:0] f_valid, f_ex, f_op, f_we, f_dest, f_alu, f_sdata, f_pc;
        logic [31:0] f_raddr, f_wen, f_wnum, f_wdata, f_rdata;
        fd = $fopen("tb/pipe_tail_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/pipe_tail_stimulus.txt");
            $display("Result: FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            text = "";
            code = $fgets(text, fd);
            // comment and blank lines scan as 0 or -1 fields
            code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f_valid, f_ex, f_op, f_we, f_dest, f_alu, f_sdata, f_pc,
                           f_raddr, f_wen, f_wnum, f_wdata, f_rdata);
            if (code == 13) begin
                lines[n_lines].valid          = f_valid[0];
                lines[n_lines].bus.ex         = f_ex[0];
                lines[n_lines].bus.mem_op     = mem_op_e'(f_op[1:0]);
                lines[n_lines].bus.gr_we      = f_we[0];
                lines[n_lines].bus.dest       = f_dest[`REG_AW-1:0];
                lines[n_lines].bus.alu_result = f_alu;
                lines[n_lines].bus.store_data = f_sdata;
                lines[n_lines].bus.pc         = f_pc;
                lines[n_lines].bus.pad        = 1'b0;
                lines[n_lines].raddr          = f_raddr[`REG_AW-1:0];
                lines[n_lines].exp_wen        = f_wen[3:0];
                lines[n_lines].exp_wnum       = f_wnum[`REG_AW-1:0];
                lines[n_lines].exp_wdata      = f_wdata;
                lines[n_lines].exp_rdata      = f_rdata;
                n_lines++;
            end else if (code > 0) begin
                $display("malformed stimulus line after entry %0d", n_lines);
                $display("Result: FAILED");
                $fatal(1, "bad stimulus");
            end
        end
        $fclose(fd);
    endtask

    // line k enters now and the readback port follows line k-3
    task drive_cycle(input int k);
        if (k < n_lines) begin
            es_to_ms_valid <= lines[k].valid;
            es_to_ms_bus   <= lines[k].bus;
        end else begin
            es_to_ms_valid <= 1'b0;   // drain
            es_to_ms_bus   <= '0;
        end
        if (k >= 3) begin
            raddr1 <= lines[k-3].raddr;
            raddr2 <= lines[k-3].raddr;
        end
    endtask

    task check_cycle(input int k);
        int                 m;
        int                 t;
        logic [`REG_AW-1:0] exp_ms_dest;
        logic [`REG_AW-1:0] exp_ws_dest;
        m           = k - 1;   // line now in the memory stage
        t           = k - 2;   // line now in writeback
        exp_ms_dest = '0;      // empty stage forwards dest 0
        exp_ws_dest = '0;
        if (m >= 0 && m < n_lines) begin
            // mem stage forwards only what will reach the rf
            if (lines[m].exp_wen != 4'h0) begin
                exp_ms_dest = lines[m].exp_wnum;
                check_value($sformatf("line %0d mem forward result", m + 1),
                            lines[m].exp_wdata, ms_fwd_result);
            end
        end
        check_value($sformatf("step %0d mem forward dest", k),
                    32'(exp_ms_dest), 32'(ms_fwd_dest));
        if (t >= 0 && t < n_lines) begin
            check_value($sformatf("line %0d trace wen", t + 1),
                        32'(lines[t].exp_wen), 32'(debug_wb_rf_wen));
            if (lines[t].valid) begin
                exp_ws_dest = lines[t].bus.dest;   // wb masks on valid only
            end
            if (lines[t].exp_wen != 4'h0) begin
                check_value($sformatf("line %0d trace pc", t + 1),
                            lines[t].bus.pc, debug_wb_pc);
                check_value($sformatf("line %0d trace wnum", t + 1),
                            32'(lines[t].exp_wnum), 32'(debug_wb_rf_wnum));
                check_value($sformatf("line %0d trace wdata", t + 1),
                            lines[t].exp_wdata, debug_wb_rf_wdata);
                check_value($sformatf("line %0d wb forward result", t + 1),
                            lines[t].exp_wdata, ws_fwd_result);
            end
        end
        check_value($sformatf("step %0d wb forward dest", k),
                    32'(exp_ws_dest), 32'(ws_fwd_dest));
        if (k >= 3) begin
            check_value($sformatf("line %0d readback port 1", k - 2),
                        lines[k-3].exp_rdata, rdata1);
            check_value($sformatf("line %0d readback port 2", k - 2),
                        lines[k-3].exp_rdata, rdata2);
        end
    endtask

    initial begin
        reset          = 1'b1;
        es_to_ms_valid = 1'b0;
        es_to_ms_bus   = '0;
        raddr1         = '0;
        raddr2         = '0;
        read_stimulus();
        cycle_limit = 4 * n_lines + 20;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int k = 0; k < n_lines + 3; k++) begin
            @(posedge clk);
            drive_cycle(k);
            @(negedge clk);   // outputs settled mid cycle
            check_cycle(k);
        end
        if (n_lines > 0 && checks_run > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("no stimulus lines were found, nothing was checked");
            $display("Result: FAILED");
            $fatal(1, "empty run");
        end
    end

endmodule
